// ==== dv/conv_2d_patterns.txt ====
// Words: 9 coefficients (bit 9 sign, bits 8:0 magnitude in 1/128), 96 input pixels
// in raster order, then 48 expected outputs as hex digits user, last, pixel byte.
020 240 010 280 140 060 018 230 220
1e 32 46 5a 6e 82 96 aa
28 3c 50 64 78 8c a0 b4
32 46 5a 6e 82 96 aa be
3c 50 64 78 8c a0 b4 c8
46 5a 6e 82 96 aa be d2
50 64 78 8c a0 b4 c8 dc
5a 1e 5a 1e 5a 1e 5a 1e
1e 5a 1e 5a 1e 5a 1e 5a
5a 1e 5a 1e 5a 1e 5a 1e
1e 5a 1e 5a 1e 5a 1e 5a
5a 1e 5a 1e 5a 1e 5a 1e
1e 5a 1e 5a 1e 5a 1e 5a
// Expected outputs, frame 1 then frame 2.
1079 009b 00bd 00df 00ff 01ff
008a 00ac 00ce 00f0 00ff 01ff
009b 00bd 00df 00ff 00ff 01ff
00ac 00ce 00f0 00ff 00ff 01ff
10db 0000 00db 0000 00db 0100
0000 00db 0000 00db 0000 01db
00db 0000 00db 0000 00db 0100
0000 00db 0000 00db 0000 01db

// ==== src.f ====
common/conv_fmt_pkg.sv
common/video_pkg.sv
window_buf/line_buf.sv
window_buf/window_buf.sv
source/pipeline_adder.sv
source/conv_2d.sv
dv/tb_conv_2d.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the conv_2d testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  -f src.f --top-module tb_conv_2d -Mdir "$OBJ_DIR" -o tb_conv_2d
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ_DIR/tb_conv_2d" | tee "$LOG"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
  echo "Simulation run returned an error status"
  exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
  echo "Failure reported in $LOG"
  exit 1
fi

echo "No failure reported in $LOG"
exit 0

// ==== dv/tb_conv_2d.sv ====
`timescale 1ns/1ps

module tb_conv_2d;

  import conv_fmt_pkg::*;

  localparam int  PX_WIDTH         = PX_WIDTH_DEF;
  localparam int  COEF_WIDTH       = COEF_WIDTH_DEF;
  localparam int  COEF_FRACT_WIDTH = COEF_FRACT_WIDTH_DEF;
  localparam int  WIN_SIZE         = 3;
  localparam int  FRAME_RES_X      = 8;
  localparam int  FRAME_RES_Y      = 6;
  localparam int  WIN_AREA         = WIN_SIZE * WIN_SIZE;
  localparam time CLK_PERIOD       = 100;
  localparam int  RESET_CYCLES     = 10;
  localparam int  FRAMES           = 2;
  localparam int  PIX_PER_FRAME    = FRAME_RES_X * FRAME_RES_Y;
  localparam int  OUT_PER_FRAME    = (FRAME_RES_X - WIN_SIZE + 1) * (FRAME_RES_Y - WIN_SIZE + 1);
  localparam int  N_PIX            = FRAMES * PIX_PER_FRAME;
  localparam int  N_OUT            = FRAMES * OUT_PER_FRAME;
  localparam int  PIX_BASE         = WIN_AREA;
  localparam int  OUT_BASE         = PIX_BASE + N_PIX;
  localparam int  PAT_WORDS        = OUT_BASE + N_OUT;
  localparam int  FIRST_WIN_PIX    = (WIN_SIZE - 1) * FRAME_RES_X + WIN_SIZE - 1;
  localparam int  EXP_LATENCY      = 2 + add_delay(WIN_AREA); // Window and multiply registers.
  localparam int  STIM_CYCLES      = RESET_CYCLES + N_PIX;
  localparam int  WATCHDOG_CYCLES  = 4 * STIM_CYCLES + 200;

  logic                           clk_i;
  logic                           rst_i;
  logic [WIN_AREA*COEF_WIDTH-1:0] coef_i;
  logic                           video_valid_i;
  px_t                            video_data_i;
  logic                           video_user_i;
  logic                           video_last_i;
  logic                           video_ready_o;
  logic                           video_valid_o;
  px_t                            video_data_o;
  logic                           video_user_o;
  logic                           video_last_o;
  logic                           video_ready_i;

  logic [15:0] pat_mem [PAT_WORDS];
  logic [15:0] lfsr;
  int          pix_idx;
  int          out_cnt;
  int          px_errors;
  int          flag_errors;
  int          cycle_errors;
  int          other_errors;
  logic        rand_on;
  logic        hold_pending;
  px_t         held_data;
  logic        held_user;
  logic        held_last;
  time         accept_time;

  conv_2d #(
    .PX_WIDTH         ( PX_WIDTH         ),
    .COEF_WIDTH       ( COEF_WIDTH       ),
    .COEF_FRACT_WIDTH ( COEF_FRACT_WIDTH ),
    .WIN_SIZE         ( WIN_SIZE         ),
    .FRAME_RES_X      ( FRAME_RES_X      ),
    .FRAME_RES_Y      ( FRAME_RES_Y      )
  ) UUT (
    .clk_i            ( clk_i            ),
    .rst_i            ( rst_i            ),
    .coef_i           ( coef_i           ),
    .video_valid_i    ( video_valid_i    ),
    .video_data_i     ( video_data_i     ),
    .video_user_i     ( video_user_i     ),
    .video_last_i     ( video_last_i     ),
    .video_ready_o    ( video_ready_o    ),
    .video_valid_o    ( video_valid_o    ),
    .video_data_o     ( video_data_o     ),
    .video_user_o     ( video_user_o     ),
    .video_last_o     ( video_last_o     ),
    .video_ready_i    ( video_ready_i    )
  );

  initial
    begin
      clk_i = 1'b0;
      forever
        #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

  // ************************************************************************
  // Random bits and compare tasks
  // ************************************************************************

  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
  endfunction

  task automatic take_bit(output logic b);
    lfsr = lfsr_next(lfsr);
    b    = lfsr[0];
  endtask

  task automatic compare_px(input string name, input px_t exp, input px_t act);
    if (act !== exp)
      begin
        $display("** Error at %0t ns: %s expected 0x%02h, got 0x%02h", $time, name, exp, act);
        px_errors++;
      end
  endtask

  task automatic compare_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
      begin
        $display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        flag_errors++;
      end
  endtask

  task automatic compare_cycles(input string name, input int exp, input int act);
    if (act != exp)
      begin
        $display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
        cycle_errors++;
      end
  endtask

  // ************************************************************************
  // Output scoreboard and stimulus
  // ************************************************************************

  task automatic check_output();
    logic [15:0] exp_word;
    if (hold_pending)
      begin
        compare_flag("video_valid_o (held)", 1'b1, video_valid_o);
        compare_px("video_data_o (held)", held_data, video_data_o);
        compare_flag("video_user_o (held)", held_user, video_user_o);
        compare_flag("video_last_o (held)", held_last, video_last_o);
      end
    // An empty or draining output lets the whole pipeline move.
    if (video_ready_i || !video_valid_o)
      compare_flag("video_ready_o", 1'b1, video_ready_o);
    if (video_valid_o && video_ready_i)
      begin
        if (out_cnt >= N_OUT)
          begin
            $display("Unexpected output beat at %0t ns after all %0d expected beats", $time, N_OUT);
            other_errors++;
          end
        else
          begin
            exp_word = pat_mem[OUT_BASE + out_cnt];
            compare_px("video_data_o", exp_word[PX_WIDTH-1:0], video_data_o);
            compare_flag("video_user_o", exp_word[12], video_user_o);
            compare_flag("video_last_o", exp_word[8], video_last_o);
            if (out_cnt == 0)
              compare_cycles("first output latency", EXP_LATENCY,
                             int'(($time - accept_time) / CLK_PERIOD));
          end
        out_cnt++;
      end
    hold_pending = video_valid_o && !video_ready_i;
    held_data    = video_data_o;
    held_user    = video_user_o;
    held_last    = video_last_o;
  endtask

  task automatic drive_ready();
    logic b0;
    logic b1;
    if (!rand_on)
      video_ready_i <= 1'b1;
    else
      begin
        take_bit(b0);
        take_bit(b1);
        video_ready_i <= !(b0 && b1); // Low about one cycle in four.
      end
  endtask

  task automatic drive_input();
    logic gap_a;
    logic gap_b;
    int   pos;
    if (video_valid_i && video_ready_o)
      begin
        if (pix_idx == FIRST_WIN_PIX)
          accept_time = $time;
        pix_idx++;
      end
    if (video_valid_i && !video_ready_o)
      return; // Beat still pending.
    gap_a = 1'b0;
    gap_b = 1'b0;
    if (rand_on)
      begin
        take_bit(gap_a);
        take_bit(gap_b);
      end
    if (pix_idx >= N_PIX || (gap_a && gap_b))
      video_valid_i <= 1'b0;
    else
      begin
        pos = pix_idx % PIX_PER_FRAME;
        video_valid_i <= 1'b1;
        video_data_i  <= pat_mem[PIX_BASE + pix_idx][PX_WIDTH-1:0];
        video_user_i  <= (pos == 0);
        video_last_i  <= (pos % FRAME_RES_X == FRAME_RES_X - 1);
      end
  endtask

  initial
    begin
      lfsr         = 16'd75;
      pix_idx      = 0;
      out_cnt      = 0;
      px_errors    = 0;
      flag_errors  = 0;
      cycle_errors = 0;
      other_errors = 0;
      rand_on      = 1'b0;
      hold_pending = 1'b0;
      held_data    = '0;
      held_user    = 1'b0;
      held_last    = 1'b0;
      accept_time  = 0;
      $readmemh("dv/conv_2d_patterns.txt", pat_mem);
      for (int k = 0; k < WIN_AREA; k++)
        coef_i[k*COEF_WIDTH +: COEF_WIDTH] = pat_mem[k][COEF_WIDTH-1:0];
      rst_i         = 1'b1;
      video_valid_i = 1'b0;
      video_data_i  = '0;
      video_user_i  = 1'b0;
      video_last_i  = 1'b0;
      video_ready_i = 1'b0;

      repeat (RESET_CYCLES)
        begin
          @(posedge clk_i);
          compare_flag("video_valid_o in reset", 1'b0, video_valid_o);
        end
      rst_i         <= 1'b0;
      video_ready_i <= 1'b1;

      // Stall free until the first output, random gaps and back-pressure after it.
      while (out_cnt < N_OUT)
        begin
          @(posedge clk_i);
          check_output();
          if (video_valid_o)
            rand_on = 1'b1;
          drive_ready();
          drive_input();
        end

      video_ready_i <= 1'b1;
      video_valid_i <= 1'b0;
      repeat (EXP_LATENCY + WIN_SIZE)
        begin
          @(posedge clk_i);
          check_output();
        end
      if (pix_idx != N_PIX)
        begin
          $display("Only %0d of %0d input pixels were accepted", pix_idx, N_PIX);
          other_errors++;
        end

      $display("Error counts: pixel %0d, flag %0d, latency %0d, other %0d",
               px_errors, flag_errors, cycle_errors, other_errors);
      if (px_errors + flag_errors + cycle_errors + other_errors == 0)
        $display("Simulation PASSED");
      else
        $display("Simulation FAILED");
      $finish;
    end

  initial
    begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Timeout after %0d cycles with %0d of %0d outputs and %0d of %0d inputs done",
               WATCHDOG_CYCLES, out_cnt, N_OUT, pix_idx, N_PIX);
      $display("Simulation FAILED");
      $finish;
    end

endmodule

// ==== source/conv_2d.sv ====
`timescale 1ns/1ps

module conv_2d #(
  parameter int PX_WIDTH         = conv_fmt_pkg::PX_WIDTH_DEF,
  parameter int COEF_WIDTH       = conv_fmt_pkg::COEF_WIDTH_DEF,
  parameter int COEF_FRACT_WIDTH = conv_fmt_pkg::COEF_FRACT_WIDTH_DEF,
  parameter int WIN_SIZE         = conv_fmt_pkg::WIN_SIZE_DEF,
  parameter int FRAME_RES_X      = video_pkg::FRAME_RES_X_DEF,
  parameter int FRAME_RES_Y      = video_pkg::FRAME_RES_Y_DEF
)(
  input  logic                                   clk_i,
  input  logic                                   rst_i,
  input  logic [WIN_SIZE*WIN_SIZE*COEF_WIDTH-1:0] coef_i,
  input  logic                                   video_valid_i,
  input  logic [PX_WIDTH-1:0]                    video_data_i,
  input  logic                                   video_user_i,
  input  logic                                   video_last_i,
  output logic                                   video_ready_o,
  output logic                                   video_valid_o,
  output logic [PX_WIDTH-1:0]                    video_data_o,
  output logic                                   video_user_o,
  output logic                                   video_last_o,
  input  logic                                   video_ready_i
);

  import conv_fmt_pkg::*;

  localparam int WIN_AREA      = WIN_SIZE * WIN_SIZE;
  localparam int CAST_WIDTH    = cast_width(PX_WIDTH, COEF_WIDTH, COEF_FRACT_WIDTH);
  localparam int MULT_WIDTH    = mult_width(PX_WIDTH, COEF_WIDTH, COEF_FRACT_WIDTH);
  localparam int PROD_WIDTH    = MULT_WIDTH - 1;
  localparam int SUM_WIDTH     = sum_width(MULT_WIDTH, WIN_AREA);
  localparam int SUM_INT_WIDTH = SUM_WIDTH - 2 * COEF_FRACT_WIDTH;
  localparam int ADD_DELAY     = add_delay(WIN_AREA);

  function automatic logic [MULT_WIDTH-1:0] sm_to_tc(input logic [MULT_WIDTH-1:0] sm);
    logic [MULT_WIDTH-1:0] mag;
    mag = {1'b0, sm[MULT_WIDTH-2:0]};
    return sm[MULT_WIDTH-1] ? ~mag + 1'b1 : mag;
  endfunction

  logic                                 win_valid;
  logic [WIN_AREA*PX_WIDTH-1:0]         win_data;
  logic                                 win_user;
  logic                                 win_last;
  logic                                 win_ready;
  logic [WIN_AREA-1:0][CAST_WIDTH-1:0]  px_cast;
  logic [WIN_AREA-1:0][CAST_WIDTH-1:0]  coef_cast;
  logic [WIN_AREA-1:0][PROD_WIDTH-1:0]  prod;
  logic [WIN_AREA-1:0][MULT_WIDTH-1:0]  mult_q;
  logic [WIN_AREA-1:0][MULT_WIDTH-1:0]  tc_mult;
  logic                                 mult_valid;
  logic                                 mult_user;
  logic                                 mult_last;
  logic                                 adder_ready;
  logic [SUM_WIDTH-1:0]                 sum;
  logic [SUM_INT_WIDTH-1:0]             sum_int;
  logic [ADD_DELAY-1:0]                 user_dly;
  logic [ADD_DELAY-1:0]                 last_dly;

  window_buf #(
    .PX_WIDTH      ( PX_WIDTH      ),
    .WIN_SIZE      ( WIN_SIZE      ),
    .FRAME_RES_X   ( FRAME_RES_X   ),
    .FRAME_RES_Y   ( FRAME_RES_Y   )
  ) window_buf_inst (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .video_valid_i ( video_valid_i ),
    .video_data_i  ( video_data_i  ),
    .video_user_i  ( video_user_i  ),
    .video_last_i  ( video_last_i  ),
    .video_ready_o ( video_ready_o ),
    .win_valid_o   ( win_valid     ),
    .win_data_o    ( win_data      ),
    .win_user_o    ( win_user      ),
    .win_last_o    ( win_last      ),
    .win_ready_i   ( win_ready     )
  );

  // ************************************************************************
  // Multiply stage
  // ************************************************************************

  assign win_ready = adder_ready || !mult_valid;

  always_comb
    for (int k = 0; k < WIN_AREA; k++)
      begin
        px_cast[k]   = CAST_WIDTH'(win_data[k*PX_WIDTH +: PX_WIDTH]) << COEF_FRACT_WIDTH;
        coef_cast[k] = CAST_WIDTH'(coef_i[k*COEF_WIDTH +: COEF_WIDTH-1]); // Magnitude.
        prod[k]      = PROD_WIDTH'(px_cast[k]) * PROD_WIDTH'(coef_cast[k]);
      end

  always_ff @(posedge clk_i)
    if (win_ready)
      for (int k = 0; k < WIN_AREA; k++)
        mult_q[k] <= {coef_i[k*COEF_WIDTH+COEF_WIDTH-1], prod[k]};

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      begin
        mult_valid <= 1'b0;
        mult_user  <= 1'b0;
        mult_last  <= 1'b0;
      end
    else if (win_ready)
      begin
        mult_valid <= win_valid;
        mult_user  <= win_user;
        mult_last  <= win_last;
      end

  always_comb
    for (int k = 0; k < WIN_AREA; k++)
      tc_mult[k] = sm_to_tc(mult_q[k]);

  pipeline_adder #(
    .NUMBERS_AMOUNT ( WIN_AREA      ),
    .NUMBER_WIDTH   ( MULT_WIDTH    )
  ) pipeline_adder_inst (
    .clk_i          ( clk_i         ),
    .rst_i          ( rst_i         ),
    .data_i         ( tc_mult       ),
    .data_valid_i   ( mult_valid    ),
    .ready_o        ( adder_ready   ),
    .data_o         ( sum           ),
    .data_valid_o   ( video_valid_o ),
    .ready_i        ( video_ready_i )
  );

  // Flags follow the adder levels and stall with them.
  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      begin
        user_dly <= '0;
        last_dly <= '0;
      end
    else if (adder_ready)
      begin
        user_dly <= {user_dly[ADD_DELAY-2:0], mult_user};
        last_dly <= {last_dly[ADD_DELAY-2:0], mult_last};
      end

  // ************************************************************************
  // Clamp to pixel range
  // ************************************************************************

  assign sum_int = sum[SUM_WIDTH-1 -: SUM_INT_WIDTH];

  always_comb
    if (sum_int[SUM_INT_WIDTH-1])
      video_data_o = '0;
    else if (|sum_int[SUM_INT_WIDTH-2:PX_WIDTH])
      video_data_o = '1;
    else
      video_data_o = sum_int[PX_WIDTH-1:0];

  assign video_user_o = user_dly[ADD_DELAY-1];
  assign video_last_o = last_dly[ADD_DELAY-1];

  a_coef_static: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (win_valid || mult_valid || video_valid_o) |-> $stable(coef_i)
  );

endmodule

// ==== source/pipeline_adder.sv ====
`timescale 1ns/1ps

module pipeline_adder #(
  parameter int NUMBERS_AMOUNT = conv_fmt_pkg::WIN_SIZE_DEF * conv_fmt_pkg::WIN_SIZE_DEF,
  parameter int NUMBER_WIDTH   = conv_fmt_pkg::mult_width(conv_fmt_pkg::PX_WIDTH_DEF,
                                                          conv_fmt_pkg::COEF_WIDTH_DEF,
                                                          conv_fmt_pkg::COEF_FRACT_WIDTH_DEF)
)(
  input  logic                                                       clk_i,
  input  logic                                                       rst_i,
  input  logic [NUMBERS_AMOUNT*NUMBER_WIDTH-1:0]                     data_i,
  input  logic                                                       data_valid_i,
  output logic                                                       ready_o,
  output logic [conv_fmt_pkg::sum_width(NUMBER_WIDTH, NUMBERS_AMOUNT)-1:0] data_o,
  output logic                                                       data_valid_o,
  input  logic                                                       ready_i
);

  import conv_fmt_pkg::*;

  localparam int ADD_DELAY = add_delay(NUMBERS_AMOUNT);

  logic [ADD_DELAY-1:0] valid_q;
  logic                 advance;

  assign advance = ready_i || !valid_q[ADD_DELAY-1]; // Whole tree moves as one.
  assign ready_o = advance;

  genvar l, i;
  generate
    for (l = 0; l < ADD_DELAY; l++)
      begin : g_lvl
        localparam int CNT  = (NUMBERS_AMOUNT + (1 << l) - 1) >> l;
        localparam int PREV = (NUMBERS_AMOUNT + (1 << l) - 2) >> (l - 1 < 0 ? 0 : l - 1);
        localparam int W    = NUMBER_WIDTH + l;

        for (i = 0; i < CNT; i++)
          begin : g_node
            logic signed [W-1:0] node_q;

            if (l == 0)
              begin : g_in
                always_ff @(posedge clk_i)
                  if (advance)
                    node_q <= data_i[i*NUMBER_WIDTH +: NUMBER_WIDTH];
              end
            else if (2 * i + 1 < PREV)
              begin : g_pair
                always_ff @(posedge clk_i)
                  if (advance)
                    node_q <= g_lvl[l-1].g_node[2*i].node_q +
                              g_lvl[l-1].g_node[2*i+1].node_q;
              end
            else
              begin : g_odd
                always_ff @(posedge clk_i)
                  if (advance)
                    node_q <= g_lvl[l-1].g_node[2*i].node_q; // Sign-extended pass.
              end
          end
      end
  endgenerate

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      valid_q <= '0;
    else if (advance)
      valid_q <= {valid_q[ADD_DELAY-2:0], data_valid_i};

  assign data_o       = g_lvl[ADD_DELAY-1].g_node[0].node_q;
  assign data_valid_o = valid_q[ADD_DELAY-1];

  a_hold_valid: assert property (
    @(posedge clk_i) disable iff (rst_i)
    data_valid_o && !ready_i |=> data_valid_o
  );

endmodule

// ==== window_buf/window_buf.sv ====
`timescale 1ns/1ps

module window_buf #(
  parameter int PX_WIDTH    = conv_fmt_pkg::PX_WIDTH_DEF,
  parameter int WIN_SIZE    = conv_fmt_pkg::WIN_SIZE_DEF,
  parameter int FRAME_RES_X = video_pkg::FRAME_RES_X_DEF,
  parameter int FRAME_RES_Y = video_pkg::FRAME_RES_Y_DEF
)(
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic                                 video_valid_i,
  input  logic [PX_WIDTH-1:0]                  video_data_i,
  input  logic                                 video_user_i,
  input  logic                                 video_last_i,
  output logic                                 video_ready_o,
  output logic                                 win_valid_o,
  output logic [WIN_SIZE*WIN_SIZE*PX_WIDTH-1:0] win_data_o,
  output logic                                 win_user_o,
  output logic                                 win_last_o,
  input  logic                                 win_ready_i
);

  import video_pkg::*;

  localparam int COL_W   = $clog2(FRAME_RES_X);
  localparam int LINE_W  = $clog2(FRAME_RES_Y + 1);
  localparam int PTR_MAX = FRAME_RES_X - 2; // Registered read adds the missing beat.

  logic                                   accept;
  logic                                   win_hit;
  logic [COL_W-1:0]                       col_cnt;
  logic [COL_W-1:0]                       lb_ptr;
  logic [LINE_W-1:0]                      line_cnt;
  logic [LINE_W-1:0]                      cur_line;
  wb_state_e                              state;
  wb_state_e                              cur_state;
  logic [PX_WIDTH-1:0]                    px_q;
  logic [WIN_SIZE-1:0][PX_WIDTH-1:0]      new_col;
  logic [WIN_SIZE-1:0][WIN_SIZE-2:0][PX_WIDTH-1:0] hist;

  assign video_ready_o = win_ready_i;
  assign accept        = video_valid_i && win_ready_i;

  // A start-of-frame beat always belongs to line 0.
  assign cur_line  = video_user_i ? '0 : line_cnt;
  assign cur_state = video_user_i ? WB_FILL : state;
  assign win_hit   = accept && (cur_state == WB_RUN) && (col_cnt >= COL_W'(WIN_SIZE - 1));

  // ************************************************************************
  // Line memories and window columns
  // ************************************************************************

  assign new_col[WIN_SIZE-1] = px_q; // Bottom row is the current line.

  genvar k, r, c;
  generate
    for (k = 0; k < WIN_SIZE - 1; k++)
      begin : g_line
        line_buf #(
          .PX_WIDTH    ( PX_WIDTH                ),
          .FRAME_RES_X ( FRAME_RES_X             )
        ) line_buf_inst (
          .clk_i       ( clk_i                   ),
          .rst_i       ( rst_i                   ),
          .en_i        ( accept                  ),
          .col_i       ( lb_ptr                  ),
          .px_i        ( new_col[WIN_SIZE-1-k]   ),
          .px_o        ( new_col[WIN_SIZE-2-k]   )
        );
      end

    for (r = 0; r < WIN_SIZE; r++)
      begin : g_row
        for (c = 0; c < WIN_SIZE - 1; c++)
          begin : g_col
            assign win_data_o[(r*WIN_SIZE+c)*PX_WIDTH +: PX_WIDTH] = hist[r][c];
          end
        assign win_data_o[(r*WIN_SIZE+WIN_SIZE-1)*PX_WIDTH +: PX_WIDTH] = new_col[r];
      end
  endgenerate

  always_ff @(posedge clk_i)
    if (accept)
      begin
        px_q <= video_data_i;
        for (int i = 0; i < WIN_SIZE; i++)
          begin
            for (int j = 0; j < WIN_SIZE - 2; j++)
              hist[i][j] <= hist[i][j+1];
            hist[i][WIN_SIZE-2] <= new_col[i];
          end
      end

  // ************************************************************************
  // Position tracking and window flags
  // ************************************************************************

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      begin
        col_cnt     <= '0;
        lb_ptr      <= '0;
        line_cnt    <= '0;
        state       <= WB_FILL;
        win_valid_o <= 1'b0;
        win_user_o  <= 1'b0;
        win_last_o  <= 1'b0;
      end
    else
      begin
        if (win_ready_i)
          begin
            win_valid_o <= win_hit;
            win_user_o  <= win_hit && (cur_line == LINE_W'(WIN_SIZE - 1)) &&
                           (col_cnt == COL_W'(WIN_SIZE - 1));
            win_last_o  <= win_hit && video_last_i;
          end
        if (accept)
          begin
            col_cnt <= video_last_i ? '0 : col_cnt + 1'b1;
            lb_ptr  <= (lb_ptr == COL_W'(PTR_MAX)) ? '0 : lb_ptr + 1'b1;
            if (video_last_i)
              begin
                line_cnt <= cur_line + 1'b1;
                state    <= (cur_line >= LINE_W'(WIN_SIZE - 2)) ? WB_RUN : cur_state;
              end
            else if (video_user_i)
              begin
                line_cnt <= '0;
                state    <= WB_FILL;
              end
          end
      end

  a_last_col: assert property (
    @(posedge clk_i) disable iff (rst_i)
    accept && video_last_i |-> (col_cnt == COL_W'(FRAME_RES_X - 1))
  );

endmodule

// ==== window_buf/line_buf.sv ====
`timescale 1ns/1ps

module line_buf #(
  parameter int PX_WIDTH    = conv_fmt_pkg::PX_WIDTH_DEF,
  parameter int FRAME_RES_X = video_pkg::FRAME_RES_X_DEF
)(
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           en_i,
  input  logic [$clog2(FRAME_RES_X)-1:0] col_i,
  input  logic [PX_WIDTH-1:0]            px_i,
  output logic [PX_WIDTH-1:0]            px_o
);

  logic [PX_WIDTH-1:0] mem [FRAME_RES_X];

  // Read-before-write on the same address.
  always_ff @(posedge clk_i)
    if (en_i)
      begin
        px_o       <= mem[col_i];
        mem[col_i] <= px_i;
      end

  a_col_range: assert property (
    @(posedge clk_i) disable iff (rst_i)
    en_i |-> (int'(col_i) < FRAME_RES_X)
  );

endmodule

// ==== common/video_pkg.sv ====
package video_pkg;

  localparam int FRAME_RES_X_DEF = 1920;
  localparam int FRAME_RES_Y_DEF = 1080;

  // ************************************************************************
  // Window buffer fill state
  // ************************************************************************

  // WB_FILL until WIN_SIZE-1 lines of the frame sit in the line memories.
  typedef enum logic {
    WB_FILL = 1'b0,
    WB_RUN  = 1'b1
  } wb_state_e;

endpackage

// ==== common/conv_fmt_pkg.sv ====
package conv_fmt_pkg;

  localparam int PX_WIDTH_DEF         = 8;
  localparam int COEF_WIDTH_DEF       = 10;
  localparam int COEF_FRACT_WIDTH_DEF = 7;
  localparam int WIN_SIZE_DEF         = 3;

  typedef logic [PX_WIDTH_DEF-1:0] px_t;

  // Magnitudes of pixels and coefficients share one unsigned fixed-point width.
  function automatic int cast_width(int px_width, int coef_width, int coef_fract_width);
    int coef_int_width;
    coef_int_width = coef_width - coef_fract_width - 1;
    return ((px_width > coef_int_width) ? px_width : coef_int_width) + coef_fract_width;
  endfunction

  function automatic int mult_width(int px_width, int coef_width, int coef_fract_width);
    return 2 * cast_width(px_width, coef_width, coef_fract_width) + 1; // Sign on top.
  endfunction

  function automatic int sum_width(int number_width, int numbers_amount);
    return number_width + $clog2(numbers_amount);
  endfunction

  function automatic int add_delay(int numbers_amount);
    return $clog2(numbers_amount) + 1; // Input register plus adder levels.
  endfunction

endpackage
